//--- files.f
src/board_pkg.sv
src/spi_host_if.sv
src/board_cfg_regs.sv
src/rtc_divider.sv
src/fan_pwm.sv
src/spi_pin_mux.sv
src/board_ctrl_top.sv
verif/board_ctrl_assert.sv
verif/board_ctrl_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module board_ctrl_tb -o Vboard_ctrl_tb
	out="$$(./obj_dir/Vboard_ctrl_tb)"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- verif/board_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_tb;

  import board_pkg::*;

  localparam int RtcHalfDiv  = 25;
  localparam int FanPrescale = 4;
  localparam int ClkPeriod   = 100;
  localparam int FanWindow   = FanSteps * FanPrescale;
  localparam int NumFanLvls  = 5;

  // Rough cycle budget per test
  localparam int RtcCycles   = 5 * RtcHalfDiv;
  localparam int RegCycles   = 8 * 24 + 2;
  localparam int OvrCycles   = 8 * 12 + 4;
  localparam int FanCycles   = NumFanLvls * (2 * FanWindow + 8);
  localparam int BootCycles  = 8 * 8;
  localparam int SpiCycles   = 32 * 2;
  localparam int TotalCycles = RtcCycles + RegCycles + OvrCycles + FanCycles + BootCycles
                             + SpiCycles + 2 + 200;

  logic       soc_clk = 1'b0;
  logic       rst_n;
  logic       reg_req;
  logic       reg_we;
  reg_addr_t  reg_addr;
  reg_data_t  reg_wdata;
  reg_data_t  reg_rdata;
  logic       reg_rvalid;
  fan_level_t fan_sw;
  boot_mode_t boot_mode_in;
  led_t       led;
  boot_mode_t boot_mode;
  logic       rtc_clk;
  logic       fan_pwm;
  logic       spih_sck;
  logic       spih_sck_en;
  spi_cs_t    spih_csb;
  spi_cs_t    spih_csb_en;
  spi_data_t  spih_sd_out;
  spi_data_t  spih_sd_en;
  spi_data_t  spih_sd_in;
  logic       sd_dat0;
  logic       sd_sclk;
  logic       sd_cmd;
  logic       sd_dat3;
  logic [1:0] sd_dat12;
  spi_data_t  flash_sd_in;
  logic       flash_sck;
  logic       flash_sck_oe;
  logic       flash_csb;
  logic       flash_csb_oe;
  spi_data_t  flash_sd;
  spi_data_t  flash_sd_oe;

  int          errors = 0;
  logic [31:0] seed = 32'hba55;

  // Software view of the register file
  led_t       model_leds = '0;
  fan_level_t model_fan  = '0;
  logic       model_ovr  = 1'b0;
  logic [2:0] model_boot = '0;

  board_ctrl_top dut0 (
    .soc_clk        ( soc_clk      ),
    .rst_n          ( rst_n        ),
    .reg_req_i      ( reg_req      ),
    .reg_we_i       ( reg_we       ),
    .reg_addr_i     ( reg_addr     ),
    .reg_wdata_i    ( reg_wdata    ),
    .reg_rdata_o    ( reg_rdata    ),
    .reg_rvalid_o   ( reg_rvalid   ),
    .fan_sw_i       ( fan_sw       ),
    .boot_mode_i    ( boot_mode_in ),
    .led_o          ( led          ),
    .boot_mode_o    ( boot_mode    ),
    .rtc_clk_o      ( rtc_clk      ),
    .fan_pwm_o      ( fan_pwm      ),
    .spih_sck_i     ( spih_sck     ),
    .spih_sck_en_i  ( spih_sck_en  ),
    .spih_csb_i     ( spih_csb     ),
    .spih_csb_en_i  ( spih_csb_en  ),
    .spih_sd_out_i  ( spih_sd_out  ),
    .spih_sd_en_i   ( spih_sd_en   ),
    .spih_sd_in_o   ( spih_sd_in   ),
    .sd_dat0_i      ( sd_dat0      ),
    .sd_sclk_o      ( sd_sclk      ),
    .sd_cmd_o       ( sd_cmd       ),
    .sd_dat3_o      ( sd_dat3      ),
    .sd_dat12_o     ( sd_dat12     ),
    .flash_sd_i     ( flash_sd_in  ),
    .flash_sck_o    ( flash_sck    ),
    .flash_sck_oe_o ( flash_sck_oe ),
    .flash_csb_o    ( flash_csb    ),
    .flash_csb_oe_o ( flash_csb_oe ),
    .flash_sd_o     ( flash_sd     ),
    .flash_sd_oe_o  ( flash_sd_oe  )
  );

  always #(ClkPeriod / 2) soc_clk = ~soc_clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic reg_data_t read_expect(input reg_addr_t addr);
    case (addr)
      RegLedsAddr:    return {24'd0, model_leds};
      RegFanCtlAddr:  return {28'd0, model_fan};
      RegFanOvrAddr:  return {31'd0, model_ovr};
      RegBootCtlAddr: return {29'd0, model_boot};
      default:        return '0;
    endcase
  endfunction

  function automatic boot_mode_t boot_expect(input logic [2:0] ctl, input boot_mode_t sw);
    return ctl[2] ? ctl[1:0] : sw;
  endfunction

  function automatic int pwm_high_expect(input int level);
    int capped;
    capped = (level > int'(FanSteps)) ? int'(FanSteps) : level;
    return capped * FanPrescale;
  endfunction

  // Packed as sclk, cmd, dat3, dat12, fsck, fsck_oe, fcsb, fcsb_oe, fsd, fsd_oe, sd_in
  function automatic logic [20:0] spi_expect(
    input logic sck, input logic sck_en, input spi_cs_t csb, input spi_cs_t csb_en,
    input spi_data_t sd_out, input spi_data_t sd_en, input logic dat0,
    input spi_data_t fl_in
  );
    spi_data_t din;
    din = '0;
    if (csb[0] == 1'b0) din[1] = dat0;
    if (csb[1] == 1'b0) din = din | fl_in;
    return {sck_en ? sck : 1'b1, sd_en[0] ? sd_out[0] : 1'b1,
            csb_en[0] ? csb[0] : 1'b1, 2'b11, sck, sck_en, csb[1], csb_en[1],
            sd_out, sd_en, din};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare and bus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("error: t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
    @(posedge soc_clk);
    reg_req   <= 1'b1;
    reg_we    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    if (!model_ovr) model_fan = fan_sw;
    case (addr)
      RegLedsAddr:    model_leds = data[7:0];
      RegFanCtlAddr:  if (model_ovr) model_fan = data[3:0];
      RegFanOvrAddr:  model_ovr = data[0];
      RegBootCtlAddr: model_boot = data[2:0];
      default:        ;
    endcase
    @(posedge soc_clk);
    reg_req <= 1'b0;
    reg_we  <= 1'b0;
  endtask

  task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
    int waited;
    @(posedge soc_clk);
    reg_req  <= 1'b1;
    reg_we   <= 1'b0;
    reg_addr <= addr;
    @(posedge soc_clk);
    reg_req <= 1'b0;
    waited = 0;
    @(negedge soc_clk);
    while (!reg_rvalid && waited < 4) begin
      @(negedge soc_clk);
      waited++;
    end
    assert (reg_rvalid) else begin
      errors++;
      $display("Read of address %0d got no valid response at t=%0t", addr, $time);
    end
    data = reg_rdata;
  endtask

  task automatic read_check(input reg_addr_t addr);
    reg_data_t data;
    bus_read(addr, data);
    check_eq($sformatf("reg_rdata_o[%0d]", addr), data, read_expect(addr));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic rtc_timing();
    int n;
    n = 0;
    do begin
      @(posedge soc_clk);
      @(negedge soc_clk);
      n++;
    end while (!rtc_clk && n < 4 * RtcHalfDiv);
    check_eq("rtc_clk_o first rise", 32'(n), 32'(RtcHalfDiv));
    repeat (3) begin
      logic last;
      last = rtc_clk;
      n = 0;
      do begin
        @(posedge soc_clk);
        @(negedge soc_clk);
        n++;
      end while (rtc_clk == last && n < 4 * RtcHalfDiv);
      check_eq("rtc_clk_o half period", 32'(n), 32'(RtcHalfDiv));
    end
  endtask

  task automatic register_access();
    repeat (8) begin
      seed = lcg_next(seed);
      bus_write(RegLedsAddr, seed);
      seed = lcg_next(seed);
      bus_write(RegBootCtlAddr, seed);
      seed = lcg_next(seed);
      bus_write(4'(4 + seed[27:24] % 12), seed);
      read_check(RegLedsAddr);
      read_check(RegBootCtlAddr);
      read_check(4'(4 + seed[19:16] % 12));
      check_eq("led_o", 32'(led), 32'(model_leds));
    end
  endtask

  task automatic fan_override();
    repeat (4) begin
      seed = lcg_next(seed);
      @(posedge soc_clk);
      fan_sw <= seed[23:20];
      @(posedge soc_clk);
      model_fan = fan_sw;
      read_check(RegFanCtlAddr);
    end
    bus_write(RegFanOvrAddr, 32'd1);
    repeat (4) begin
      seed = lcg_next(seed);
      bus_write(RegFanCtlAddr, seed);
      @(posedge soc_clk);
      fan_sw <= seed[11:8];
      read_check(RegFanCtlAddr);
    end
  endtask

  task automatic fan_duty();
    int levels [NumFanLvls] = '{0, 3, 8, 12, 15};
    int high;
    foreach (levels[i]) begin
      bus_write(RegFanCtlAddr, 32'(levels[i]));
      // Let one full period pass with the new setting
      repeat (FanWindow) @(posedge soc_clk);
      high = 0;
      repeat (FanWindow) begin
        @(negedge soc_clk);
        if (fan_pwm) high++;
      end
      check_eq("fan_pwm_o high cycles", 32'(high), 32'(pwm_high_expect(levels[i])));
    end
  endtask

  task automatic boot_select();
    repeat (8) begin
      seed = lcg_next(seed);
      bus_write(RegBootCtlAddr, seed >> 8);
      repeat (3) begin
        seed = lcg_next(seed);
        @(posedge soc_clk);
        boot_mode_in <= seed[17:16];
        @(negedge soc_clk);
        check_eq("boot_mode_o", 32'(boot_mode), 32'(boot_expect(model_boot, boot_mode_in)));
      end
    end
  endtask

  task automatic spi_mapping();
    logic [20:0] pins_exp;
    repeat (32) begin
      seed = lcg_next(seed);
      @(posedge soc_clk);
      {spih_sck, spih_sck_en, spih_csb, spih_csb_en} <= seed[31:26];
      {spih_sd_out, spih_sd_en} <= seed[23:16];
      {sd_dat0, flash_sd_in} <= seed[14:10];
      @(negedge soc_clk);
      pins_exp = spi_expect(spih_sck, spih_sck_en, spih_csb, spih_csb_en, spih_sd_out,
                            spih_sd_en, sd_dat0, flash_sd_in);
      check_eq("sd_sclk_o", 32'(sd_sclk), 32'(pins_exp[20]));
      check_eq("sd_cmd_o", 32'(sd_cmd), 32'(pins_exp[19]));
      check_eq("sd_dat3_o", 32'(sd_dat3), 32'(pins_exp[18]));
      check_eq("sd_dat12_o", 32'(sd_dat12), 32'(pins_exp[17:16]));
      check_eq("flash_sck_o", 32'(flash_sck), 32'(pins_exp[15]));
      check_eq("flash_sck_oe_o", 32'(flash_sck_oe), 32'(pins_exp[14]));
      check_eq("flash_csb_o", 32'(flash_csb), 32'(pins_exp[13]));
      check_eq("flash_csb_oe_o", 32'(flash_csb_oe), 32'(pins_exp[12]));
      check_eq("flash_sd_o", 32'(flash_sd), 32'(pins_exp[11:8]));
      check_eq("flash_sd_oe_o", 32'(flash_sd_oe), 32'(pins_exp[7:4]));
      check_eq("spih_sd_in_o", 32'(spih_sd_in), 32'(pins_exp[3:0]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    reg_req      = 1'b0;
    reg_we       = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    fan_sw       = 4'd5;
    boot_mode_in = '0;
    spih_sck     = 1'b0;
    spih_sck_en  = 1'b0;
    spih_csb     = 2'b11;
    spih_csb_en  = '0;
    spih_sd_out  = '0;
    spih_sd_en   = '0;
    sd_dat0      = 1'b0;
    flash_sd_in  = '0;
    repeat (2) @(posedge soc_clk);
    rst_n <= 1'b1;
    rtc_timing();
    register_access();
    fan_override();
    fan_duty();
    boot_select();
    spi_mapping();
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(longint'(TotalCycles) * ClkPeriod);
    $display("Watchdog expired after %0d cycles, %0d errors so far", TotalCycles, errors);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/board_ctrl_assert.sv
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_assert #(
  parameter int RtcHalfDiv = 25
) (
  input wire                  soc_clk,
  input wire                  rst_n,
  input wire                  reg_req_i,
  input wire                  reg_we_i,
  input wire                  reg_rvalid_o,
  input wire                  rtc_clk_o,
  input wire                  spih_sck_en_i,
  input board_pkg::spi_cs_t   spih_csb_en_i,
  input board_pkg::spi_data_t spih_sd_en_i,
  input wire                  sd_sclk_o,
  input wire                  sd_cmd_o,
  input wire                  sd_dat3_o
);

  int since_q;

  // Starts at -1 so the first toggle counts from the release edge
  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      since_q <= -1;
    end else if ($changed(rtc_clk_o)) begin
      since_q <= 0;
    end else begin
      since_q <= since_q + 1;
    end
  end

  rtc_steady: assert property (@(posedge soc_clk) disable iff (!rst_n)
    $changed(rtc_clk_o) |-> since_q == RtcHalfDiv - 1)
    else $error("rtc_clk_o toggled after %0d cycles", since_q + 1);

  rvalid_follows: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (reg_req_i && !reg_we_i) |=> reg_rvalid_o)
    else $error("reg_rvalid_o missing after read request");

  rvalid_only_after_read: assert property (@(posedge soc_clk) disable iff (!rst_n)
    reg_rvalid_o |-> $past(reg_req_i && !reg_we_i))
    else $error("reg_rvalid_o without read request");

  sd_idle_high: assert property (@(posedge soc_clk) disable iff (!rst_n)
    (!spih_sck_en_i -> sd_sclk_o) && (!spih_csb_en_i[0] -> sd_dat3_o)
    && (!spih_sd_en_i[0] -> sd_cmd_o))
    else $error("SD pin low while its enable is off");

endmodule

bind board_ctrl_top board_ctrl_assert #(
  .RtcHalfDiv ( RtcHalfDiv )
) u_board_ctrl_assert (
  .soc_clk       ( soc_clk       ),
  .rst_n         ( rst_n         ),
  .reg_req_i     ( reg_req_i     ),
  .reg_we_i      ( reg_we_i      ),
  .reg_rvalid_o  ( reg_rvalid_o  ),
  .rtc_clk_o     ( rtc_clk_o     ),
  .spih_sck_en_i ( spih_sck_en_i ),
  .spih_csb_en_i ( spih_csb_en_i ),
  .spih_sd_en_i  ( spih_sd_en_i  ),
  .sd_sclk_o     ( sd_sclk_o     ),
  .sd_cmd_o      ( sd_cmd_o      ),
  .sd_dat3_o     ( sd_dat3_o     )
);

`default_nettype wire

//--- src/board_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_top #(
  parameter int unsigned RtcHalfDiv  = 25,
  parameter int unsigned FanPrescale = 4
) (
  input  wire                     soc_clk,
  input  wire                     rst_n,

  // Register bus
  input  wire                     reg_req_i,
  input  wire                     reg_we_i,
  input  board_pkg::reg_addr_t    reg_addr_i,
  input  board_pkg::reg_data_t    reg_wdata_i,
  output board_pkg::reg_data_t    reg_rdata_o,
  output logic                    reg_rvalid_o,

  // Board switches and indicators
  input  board_pkg::fan_level_t   fan_sw_i,
  input  board_pkg::boot_mode_t   boot_mode_i,
  output board_pkg::led_t         led_o,
  output board_pkg::boot_mode_t   boot_mode_o,
  output logic                    rtc_clk_o,
  output logic                    fan_pwm_o,

  // SoC SPI host
  input  wire                     spih_sck_i,
  input  wire                     spih_sck_en_i,
  input  board_pkg::spi_cs_t      spih_csb_i,
  input  board_pkg::spi_cs_t      spih_csb_en_i,
  input  board_pkg::spi_data_t    spih_sd_out_i,
  input  board_pkg::spi_data_t    spih_sd_en_i,
  output board_pkg::spi_data_t    spih_sd_in_o,

  // SD card pins
  input  wire                     sd_dat0_i,
  output logic                    sd_sclk_o,
  output logic                    sd_cmd_o,
  output logic                    sd_dat3_o,
  output logic [1:0]              sd_dat12_o,

  // Flash pins
  input  board_pkg::spi_data_t    flash_sd_i,
  output logic                    flash_sck_o,
  output logic                    flash_sck_oe_o,
  output logic                    flash_csb_o,
  output logic                    flash_csb_oe_o,
  output board_pkg::spi_data_t    flash_sd_o,
  output board_pkg::spi_data_t    flash_sd_oe_o
);

  board_pkg::fan_level_t fan_level;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////////////////////

  board_cfg_regs i_cfg_regs (
    .soc_clk      ( soc_clk      ),
    .rst_n        ( rst_n        ),
    .reg_req_i    ( reg_req_i    ),
    .reg_we_i     ( reg_we_i     ),
    .reg_addr_i   ( reg_addr_i   ),
    .reg_wdata_i  ( reg_wdata_i  ),
    .fan_sw_i     ( fan_sw_i     ),
    .boot_mode_i  ( boot_mode_i  ),
    .reg_rdata_o  ( reg_rdata_o  ),
    .reg_rvalid_o ( reg_rvalid_o ),
    .led_o        ( led_o        ),
    .fan_level_o  ( fan_level    ),
    .boot_mode_o  ( boot_mode_o  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // RTC and fan
  ////////////////////////////////////////////////////////////////////////////

  rtc_divider #(
    .RtcHalfDiv ( RtcHalfDiv )
  ) i_rtc_divider (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .rtc_clk_o ( rtc_clk_o )
  );

  fan_pwm #(
    .FanPrescale ( FanPrescale )
  ) i_fan_pwm (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .fan_level_i ( fan_level ),
    .fan_pwm_o   ( fan_pwm_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // SPI host to SD and flash
  ////////////////////////////////////////////////////////////////////////////

  spi_host_if spi_bus ();

  assign spi_bus.sck    = spih_sck_i;
  assign spi_bus.sck_en = spih_sck_en_i;
  assign spi_bus.csb    = spih_csb_i;
  assign spi_bus.csb_en = spih_csb_en_i;
  assign spi_bus.sd_out = spih_sd_out_i;
  assign spi_bus.sd_en  = spih_sd_en_i;
  assign spih_sd_in_o   = spi_bus.sd_in;

  spi_pin_mux i_spi_pin_mux (
    .spi            ( spi_bus.pins   ),
    .sd_dat0_i      ( sd_dat0_i      ),
    .flash_sd_i     ( flash_sd_i     ),
    .sd_sclk_o      ( sd_sclk_o      ),
    .sd_cmd_o       ( sd_cmd_o       ),
    .sd_dat3_o      ( sd_dat3_o      ),
    .sd_dat12_o     ( sd_dat12_o     ),
    .flash_sck_o    ( flash_sck_o    ),
    .flash_sck_oe_o ( flash_sck_oe_o ),
    .flash_csb_o    ( flash_csb_o    ),
    .flash_csb_oe_o ( flash_csb_oe_o ),
    .flash_sd_o     ( flash_sd_o     ),
    .flash_sd_oe_o  ( flash_sd_oe_o  )
  );

endmodule

`default_nettype wire

//--- src/spi_pin_mux.sv
`timescale 1ns/1ps
`default_nettype none

module spi_pin_mux (
  spi_host_if.pins        spi,
  input  wire             sd_dat0_i,
  input  board_pkg::spi_data_t flash_sd_i,
  output logic            sd_sclk_o,
  output logic            sd_cmd_o,
  output logic            sd_dat3_o,
  output logic [1:0]      sd_dat12_o,
  output logic            flash_sck_o,
  output logic            flash_sck_oe_o,
  output logic            flash_csb_o,
  output logic            flash_csb_oe_o,
  output board_pkg::spi_data_t flash_sd_o,
  output board_pkg::spi_data_t flash_sd_oe_o
);

  import board_pkg::*;

  spi_data_t sd_in;

  ////////////////////////////////////////////////////////////////////////////
  // SD card in SPI mode with idle pins pulled high
  ////////////////////////////////////////////////////////////////////////////

  assign sd_sclk_o  = spi.sck_en          ? spi.sck          : 1'b1;
  assign sd_dat3_o  = spi.csb_en[SdCsIdx] ? spi.csb[SdCsIdx] : 1'b1;
  // MOSI on CMD
  assign sd_cmd_o   = spi.sd_en[0]        ? spi.sd_out[0]    : 1'b1;
  // DAT1 and DAT2 unused in SPI mode
  assign sd_dat12_o = 2'b11;

  ////////////////////////////////////////////////////////////////////////////
  // Quad SPI flash
  ////////////////////////////////////////////////////////////////////////////

  assign flash_sck_o    = spi.sck;
  assign flash_sck_oe_o = spi.sck_en;
  assign flash_csb_o    = spi.csb[FlashCsIdx];
  assign flash_csb_oe_o = spi.csb_en[FlashCsIdx];
  assign flash_sd_o     = spi.sd_out;
  assign flash_sd_oe_o  = spi.sd_en;

  // Input data from whichever device is selected
  always_comb begin
    sd_in = '0;
    if (!spi.csb[SdCsIdx]) begin
      sd_in[1] = sd_dat0_i;  // MISO on DAT0
    end
    if (!spi.csb[FlashCsIdx]) begin
      sd_in = sd_in | flash_sd_i;
    end
  end

  assign spi.sd_in = sd_in;

endmodule

`default_nettype wire

//--- src/fan_pwm.sv
`timescale 1ns/1ps
`default_nettype none

module fan_pwm #(
  parameter int unsigned FanPrescale = 4
) (
  input  wire                    soc_clk,
  input  wire                    rst_n,
  input  board_pkg::fan_level_t  fan_level_i,
  output logic                   fan_pwm_o
);

  import board_pkg::*;

  localparam int unsigned PreWidth = (FanPrescale > 1) ? $clog2(FanPrescale) : 1;

  logic [PreWidth-1:0] pre_q;
  logic                pre_wrap;
  fan_level_t          step_q;
  logic                pwm_q;

  assign pre_wrap = (pre_q == PreWidth'(FanPrescale - 1));

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      pre_q  <= '0;
      step_q <= '0;
      pwm_q  <= 1'b0;
    end else begin
      if (pre_wrap) begin
        pre_q <= '0;
        // Step counter runs 0 .. FanSteps-1
        if (step_q == fan_level_t'(FanSteps - 1)) begin
          step_q <= '0;
        end else begin
          step_q <= step_q + 1'b1;
        end
      end else begin
        pre_q <= pre_q + 1'b1;
      end
      // Top setting stays above every step and keeps the fan on
      pwm_q <= (step_q < fan_level_i);
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

`default_nettype wire

//--- src/rtc_divider.sv
`timescale 1ns/1ps
`default_nettype none

module rtc_divider #(
  parameter int unsigned RtcHalfDiv = 25
) (
  input  wire  soc_clk,
  input  wire  rst_n,
  output logic rtc_clk_o
);

  localparam int unsigned CntWidth = (RtcHalfDiv > 1) ? $clog2(RtcHalfDiv) : 1;

  logic [CntWidth-1:0] cnt_q;
  logic                rtc_q;
  logic                wrap;

  // Half period is over
  assign wrap = (cnt_q == CntWidth'(RtcHalfDiv - 1));

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      if (wrap) begin
        cnt_q <= '0;
        rtc_q <= ~rtc_q;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign rtc_clk_o = rtc_q;

endmodule

`default_nettype wire

//--- src/board_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module board_cfg_regs (
  input  wire                     soc_clk,
  input  wire                     rst_n,
  input  wire                     reg_req_i,
  input  wire                     reg_we_i,
  input  board_pkg::reg_addr_t    reg_addr_i,
  input  board_pkg::reg_data_t    reg_wdata_i,
  input  board_pkg::fan_level_t   fan_sw_i,
  input  board_pkg::boot_mode_t   boot_mode_i,
  output board_pkg::reg_data_t    reg_rdata_o,
  output logic                    reg_rvalid_o,
  output board_pkg::led_t         led_o,
  output board_pkg::fan_level_t   fan_level_o,
  output board_pkg::boot_mode_t   boot_mode_o
);

  import board_pkg::*;

  led_t       leds_q;
  fan_level_t fan_ctl_q;
  logic       fan_ovr_q;
  boot_mode_t boot_ovr_q;
  logic       boot_sel_q;

  logic       wr_en;
  logic       rd_en;
  reg_data_t  rdata_d;
  reg_data_t  rdata_q;
  logic       rvalid_q;

  assign wr_en = reg_req_i & reg_we_i;
  assign rd_en = reg_req_i & ~reg_we_i;

  ////////////////////////////////////////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      leds_q     <= '0;
      fan_ctl_q  <= '0;
      fan_ovr_q  <= 1'b0;
      boot_ovr_q <= '0;
      boot_sel_q <= 1'b0;
    end else begin
      if (wr_en && reg_addr_i == RegLedsAddr) begin
        leds_q <= reg_wdata_i[LedWidth-1:0];
      end
      if (wr_en && reg_addr_i == RegFanOvrAddr) begin
        fan_ovr_q <= reg_wdata_i[0];
      end
      if (wr_en && reg_addr_i == RegBootCtlAddr) begin
        boot_ovr_q <= reg_wdata_i[1:0];
        boot_sel_q <= reg_wdata_i[2];
      end
      // Switches own FAN_CTL until software takes over
      if (!fan_ovr_q) begin
        fan_ctl_q <= fan_sw_i;
      end else if (wr_en && reg_addr_i == RegFanCtlAddr) begin
        fan_ctl_q <= reg_wdata_i[$bits(fan_level_t)-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      RegLedsAddr:    rdata_d[LedWidth-1:0]         = leds_q;
      RegFanCtlAddr:  rdata_d[$bits(fan_level_t)-1:0] = fan_ctl_q;
      RegFanOvrAddr:  rdata_d[0]                    = fan_ovr_q;
      RegBootCtlAddr: rdata_d[2:0]                  = {boot_sel_q, boot_ovr_q};
      default:        rdata_d = '0;
    endcase
  end

  always_ff @(posedge soc_clk, negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= rd_en;
      if (rd_en) begin
        rdata_q <= rdata_d;
      end
    end
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;

  // Outputs to board logic
  assign led_o       = leds_q;
  assign fan_level_o = fan_ctl_q;
  assign boot_mode_o = boot_sel_q ? boot_ovr_q : boot_mode_i;

endmodule

`default_nettype wire

//--- src/spi_host_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spi_host_if;

  // Clock and its enable
  logic                 sck;
  logic                 sck_en;

  // Chip selects with per-select enables
  board_pkg::spi_cs_t   csb;
  board_pkg::spi_cs_t   csb_en;

  // Quad data lanes
  board_pkg::spi_data_t sd_out;
  board_pkg::spi_data_t sd_en;
  board_pkg::spi_data_t sd_in;

  // SoC side
  modport host (
    output sck, sck_en, csb, csb_en, sd_out, sd_en,
    input  sd_in
  );

  // Board pin side
  modport pins (
    input  sck, sck_en, csb, csb_en, sd_out, sd_en,
    output sd_in
  );

endinterface

`default_nettype wire

//--- src/board_pkg.sv
`default_nettype none

package board_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned LedWidth = 8;

  // PWM steps in one fan period
  localparam int unsigned FanSteps = 15;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [3:0]          reg_addr_t;
  typedef logic [31:0]         reg_data_t;
  typedef logic [LedWidth-1:0] led_t;

  // 0 is off and 15 is always on
  typedef logic [3:0]          fan_level_t;

  typedef logic [1:0]          boot_mode_t;

  // Chip selects are active low
  typedef logic [1:0]          spi_cs_t;
  typedef logic [3:0]          spi_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Register map in word addresses
  ////////////////////////////////////////////////////////////////////////////

  localparam reg_addr_t RegLedsAddr    = 4'd0;
  localparam reg_addr_t RegFanCtlAddr  = 4'd1;
  localparam reg_addr_t RegFanOvrAddr  = 4'd2;
  localparam reg_addr_t RegBootCtlAddr = 4'd3;

  ////////////////////////////////////////////////////////////////////////////
  // SPI chip select assignment
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned SdCsIdx    = 0;
  localparam int unsigned FlashCsIdx = 1;

endpackage

`default_nettype wire
